/* avmm_pkg.sv */
// --------------------
// Avalon side of the bridge
// Addresses count 64-bit lines, not bytes
// Burstcount is 1-based, legal range 1 to AVMM_MAX_BURST
// --------------------

package avmm_pkg;

    // Line address toward the master
    localparam int AVMM_ADDR_W = 10;

    // One line per beat
    localparam int AVMM_DATA_W = 64;

    // One enable bit per data byte
    localparam int AVMM_BE_W = AVMM_DATA_W / 8;

    // Wide enough to hold AVMM_MAX_BURST itself
    localparam int AVMM_BURST_W = 4;

    // Longest burst the master may request
    localparam int AVMM_MAX_BURST = 8;

endpackage

/* avmm_reg_stage.sv */
// --------------------
// Two-entry skid buffer on the Avalon request path
// waitrequest is a flop; it rises only once the skid entry is full
// Master must hold its request while waitrequest is high
// --------------------

`timescale 1ns/1ps

module avmm_reg_stage
    import avmm_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,

    // From the master
    input  logic [AVMM_ADDR_W-1:0]  address,
    input  logic [AVMM_BURST_W-1:0] burstcount,
    input  logic                    read,
    input  logic                    write,
    input  logic [AVMM_DATA_W-1:0]  writedata,
    input  logic [AVMM_BE_W-1:0]    byteenable,
    output logic                    waitrequest,

    // Toward the mapper
    output logic [AVMM_ADDR_W-1:0]  q_address,
    output logic [AVMM_BURST_W-1:0] q_burstcount,
    output logic                    q_read,
    output logic                    q_write,
    output logic [AVMM_DATA_W-1:0]  q_writedata,
    output logic [AVMM_BE_W-1:0]    q_byteenable,
    input  logic                    q_waitrequest
);

    logic                    out_valid;
    logic                    out_read;
    logic                    out_write;
    logic                    skid_valid;
    logic [AVMM_ADDR_W-1:0]  skid_address;
    logic [AVMM_BURST_W-1:0] skid_burstcount;
    logic                    skid_read;
    logic                    skid_write;
    logic [AVMM_DATA_W-1:0]  skid_writedata;
    logic [AVMM_BE_W-1:0]    skid_byteenable;
    logic                    in_fire;
    logic                    out_fire;
    logic                    out_load;

    // Skid entry full is exactly the stall condition
    assign waitrequest = skid_valid;

    assign in_fire  = (read || write) && !waitrequest;
    assign out_fire = out_valid && !q_waitrequest;

    // Output entry takes a new word when empty or draining
    assign out_load = !out_valid || out_fire;

    assign q_read  = out_valid && out_read;
    assign q_write = out_valid && out_write;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end
        else if (out_load)
        begin
            // Skid drains first; waitrequest blocks new input meanwhile
            out_valid  <= skid_valid || in_fire;
            skid_valid <= 1'b0;
        end
        else if (in_fire)
        begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        // Skid tracks the input until it holds a parked word
        if (!skid_valid)
        begin
            skid_address    <= address;
            skid_burstcount <= burstcount;
            skid_read       <= read;
            skid_write      <= write;
            skid_writedata  <= writedata;
            skid_byteenable <= byteenable;
        end

        if (out_load)
        begin
            q_address    <= skid_valid ? skid_address    : address;
            q_burstcount <= skid_valid ? skid_burstcount : burstcount;
            out_read     <= skid_valid ? skid_read       : read;
            out_write    <= skid_valid ? skid_write      : write;
            q_writedata  <= skid_valid ? skid_writedata  : writedata;
            q_byteenable <= skid_valid ? skid_byteenable : byteenable;
        end
    end

    // A beat is either a read or a write, never both
    a_one_cmd_per_beat: assert property (
        @(posedge clk) disable iff (!rst_n)
        (read || write) && !waitrequest |-> !(read && write)
    );

endmodule

/* avmm_to_axi_mapper.sv */
// --------------------
// Avalon requests onto AXI channels, fully combinational
// AW and first W beat go together; bready and rready are always high
// Responses are always OKAY and arrive in order
// --------------------

`timescale 1ns/1ps

module avmm_to_axi_mapper
    import avmm_pkg::*, axi_mem_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,

    // Registered Avalon requests
    input  logic [AVMM_ADDR_W-1:0]  q_address,
    input  logic [AVMM_BURST_W-1:0] q_burstcount,
    input  logic                    q_read,
    input  logic                    q_write,
    input  logic [AVMM_DATA_W-1:0]  q_writedata,
    input  logic [AVMM_BE_W-1:0]    q_byteenable,
    output logic                    q_waitrequest,

    // Write address
    output logic                    awvalid,
    input  logic                    awready,
    output t_axi_addr               awaddr,
    output logic [AXI_LEN_W-1:0]    awlen,

    // Write data
    output logic                    wvalid,
    input  logic                    wready,
    output logic [AVMM_DATA_W-1:0]  wdata,
    output logic [AVMM_BE_W-1:0]    wstrb,
    output logic                    wlast,

    // Write response
    input  logic                    bvalid,

    // Read address
    output logic                    arvalid,
    input  logic                    arready,
    output t_axi_addr               araddr,
    output logic [AXI_LEN_W-1:0]    arlen,

    // Read data
    input  logic                    rvalid,
    input  logic [AVMM_DATA_W-1:0]  rdata,

    // Responses back to Avalon
    output logic [AVMM_DATA_W-1:0]  readdata,
    output logic                    readdatavalid,
    output logic                    writeresponsevalid
);

    logic                    wr_sop;
    logic                    wr_eop;
    logic                    wr_ready;
    logic [AVMM_BURST_W-1:0] burst_m1;

    // Data channel must be ready; address channel too on the first beat
    assign wr_ready = wready && (!wr_sop || awready);

    burst_sop_tracker wr_bursts
    (
        .clk,
        .rst_n,
        .beat_valid (q_write && wr_ready),
        .burstcount (q_burstcount),
        .sop        (wr_sop),
        .eop        (wr_eop)
    );

    // Stall by request type
    assign q_waitrequest = q_write ? !wr_ready : !arready;

    // 1-based count to 0-based length
    assign burst_m1 = q_burstcount - 1'b1;

    always_comb
    begin
        // Write address, issued with the first data beat
        awvalid           = q_write && wr_ready && wr_sop;
        awaddr.l.line     = q_address;
        awaddr.l.byte_idx = '0;
        awlen             = burst_m1[AXI_LEN_W-1:0];

        // Write data
        wvalid = q_write && wr_ready;
        wdata  = q_writedata;
        wstrb  = q_byteenable;
        wlast  = wr_eop;

        // Read address, one per read request
        arvalid           = q_read && arready;
        araddr.l.line     = q_address;
        araddr.l.byte_idx = '0;
        arlen             = burst_m1[AXI_LEN_W-1:0];

        // bready and rready are tied high, so responses pass straight through
        writeresponsevalid = bvalid;
        readdatavalid      = rvalid;
        readdata           = rdata;
    end

    // Reads never cut into an open write burst
    a_no_read_in_burst: assert property (
        @(posedge clk) disable iff (!rst_n)
        q_read |-> wr_sop
    );

endmodule

/* axi_local_mem.sv */
// --------------------
// In-order AXI slave memory, one line per beat
// Expects the first W beat together with AW, as the mapper sends it
// INCR bursts of full-width beats only, responses always OKAY
// bready and rready are taken as always high
// --------------------

`timescale 1ns/1ps

module axi_local_mem
    import avmm_pkg::*, axi_mem_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,

    // Write address
    input  logic                   awvalid,
    output logic                   awready,
    input  t_axi_addr              awaddr,
    input  logic [AXI_LEN_W-1:0]   awlen,

    // Write data
    input  logic                   wvalid,
    output logic                   wready,
    input  logic [AVMM_DATA_W-1:0] wdata,
    input  logic [AVMM_BE_W-1:0]   wstrb,
    input  logic                   wlast,

    // Write response
    output logic                   bvalid,

    // Read address
    input  logic                   arvalid,
    output logic                   arready,
    input  t_axi_addr              araddr,
    input  logic [AXI_LEN_W-1:0]   arlen,

    // Read data
    output logic                   rvalid,
    output logic [AVMM_DATA_W-1:0] rdata,
    output logic                   rlast
);

    logic [AVMM_DATA_W-1:0] mem [MEM_LINES];

    // Write engine
    logic                  wr_busy;
    logic [AXI_LINE_W-1:0] wr_line;
    logic [AXI_LEN_W-1:0]  wr_cnt;
    logic [AXI_LEN_W-1:0]  wr_len;
    logic                  w_fire;
    logic [AXI_LINE_W-1:0] w_line;
    logic [AXI_LEN_W-1:0]  beat_idx;
    logic [AXI_LEN_W-1:0]  beat_len;

    // Read engine
    logic [AXI_LINE_W-1:0] rd_line;
    logic [AXI_LEN_W-1:0]  rd_left;
    logic                  ar_fire;
    logic                  rd_active;
    logic [AXI_LINE_W-1:0] rd_src_line;

    // Idle and not answering, so a new burst may start
    assign awready = !wr_busy && !bvalid;
    assign wready  = !bvalid;

    // Outside a burst a beat counts only with its address
    assign w_fire = wvalid && wready && (wr_busy || awvalid);

    // First beat takes line and length straight off the bus
    assign w_line   = wr_busy ? wr_line : awaddr.l.line;
    assign beat_idx = wr_busy ? wr_cnt  : '0;
    assign beat_len = wr_busy ? wr_len  : awlen;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_busy <= 1'b0;
            bvalid  <= 1'b0;
        end
        else
        begin
            // One response pulse, the cycle after wlast
            bvalid <= w_fire && wlast;
            if (w_fire)
                wr_busy <= !wlast;
        end
    end

    always_ff @(posedge clk)
    begin
        if (w_fire)
        begin
            wr_line <= w_line + 1'b1;
            wr_cnt  <= beat_idx + 1'b1;
            if (!wr_busy)
                wr_len <= awlen;
        end
    end

    // Byte merge under wstrb
    always_ff @(posedge clk)
    begin
        if (w_fire)
        begin
            for (int i = 0; i < AVMM_BE_W; i++)
            begin
                if (wstrb[i])
                    mem[w_line][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    // Beats left after the current one; zero means idle
    assign arready   = (rd_left == '0);
    assign ar_fire   = arvalid && arready;
    assign rd_active = ar_fire || !arready;

    assign rd_src_line = ar_fire ? araddr.l.line : rd_line;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            rd_left <= '0;
        end
        else if (ar_fire)
        begin
            rvalid  <= 1'b1;
            rlast   <= (arlen == '0);
            rd_left <= arlen;
        end
        else if (rd_active)
        begin
            rvalid  <= 1'b1;
            rlast   <= (rd_left == AXI_LEN_W'(1));
            rd_left <= rd_left - 1'b1;
        end
        else
        begin
            rvalid <= 1'b0;
            rlast  <= 1'b0;
        end
    end

    // Registered read, one line per cycle
    always_ff @(posedge clk)
    begin
        if (rd_active)
        begin
            rdata   <= mem[rd_src_line];
            rd_line <= rd_src_line + 1'b1;
        end
    end

    // Master's wlast must agree with the length it gave on AW
    a_wlast_on_len: assert property (
        @(posedge clk) disable iff (!rst_n)
        w_fire |-> (wlast == (beat_idx == beat_len))
    );

endmodule

/* axi_mem_pkg.sv */
// --------------------
// AXI side of the bridge
// Beats are always full width, so size is fixed
// Widths derive from the Avalon side
// --------------------

package axi_mem_pkg;

    import avmm_pkg::*;

    // Size code of an 8-byte beat
    localparam logic [2:0] AXI_SIZE_BEAT = 3'($clog2(AVMM_BE_W));

    // Low byte-index bits, zero for full-width beats
    localparam int AXI_BYTE_IDX_W = int'(AXI_SIZE_BEAT);

    // Line part of the byte address
    localparam int AXI_LINE_W = AVMM_ADDR_W;

    localparam int AXI_ADDR_W = AXI_LINE_W + AXI_BYTE_IDX_W;

    // AXI length is 0-based, so one bit narrower than burstcount
    localparam int AXI_LEN_W = AVMM_BURST_W - 1;

    // Every line address has a word behind it
    localparam int MEM_LINES = 1 << AXI_LINE_W;

    // Line view of a byte address
    typedef struct packed {
        logic [AXI_LINE_W-1:0]     line;
        logic [AXI_BYTE_IDX_W-1:0] byte_idx;
    } t_axi_line_addr;

    // One address word, read either flat or split into line and byte index
    typedef union packed {
        logic [AXI_ADDR_W-1:0] byte_addr;
        t_axi_line_addr        l;
    } t_axi_addr;

endpackage

/* burst_sop_tracker.sv */
// --------------------
// Marks first and last beat of Avalon bursts
// burstcount is sampled on the start beat only
// --------------------

`timescale 1ns/1ps

module burst_sop_tracker
    import avmm_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    beat_valid,
    input  logic [AVMM_BURST_W-1:0] burstcount,

    output logic                    sop,
    output logic                    eop
);

    // Beats still to come in the open burst
    logic [AVMM_BURST_W-1:0] beats_left;

    // No open burst, so the next beat starts one
    assign sop = (beats_left == '0);

    // Last beat when only this one remains
    assign eop = sop ? (burstcount == AVMM_BURST_W'(1)) : (beats_left == AVMM_BURST_W'(1));

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            beats_left <= '0;
        end
        else if (beat_valid)
        begin
            if (sop)
                beats_left <= burstcount - 1'b1;
            else
                beats_left <= beats_left - 1'b1;
        end
    end

    // Zero or oversize bursts would wrap the counter
    a_legal_burst: assert property (
        @(posedge clk) disable iff (!rst_n)
        beat_valid && sop |-> (burstcount != '0) && (burstcount <= AVMM_MAX_BURST)
    );

endmodule

/* flist.f */
avmm_pkg.sv
axi_mem_pkg.sv
avmm_reg_stage.sv
burst_sop_tracker.sv
avmm_to_axi_mapper.sv
axi_local_mem.sv
local_mem_avmm_bridge.sv
tb_local_mem_avmm_bridge.sv

/* local_mem_avmm_bridge.sv */
// --------------------
// Avalon master port onto AXI local memory, single clock
// Read latency is two cycles minimum from acceptance
// One writeresponsevalid pulse per write burst
// --------------------

`timescale 1ns/1ps

module local_mem_avmm_bridge
    import avmm_pkg::*, axi_mem_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic [AVMM_ADDR_W-1:0]  address,
    input  logic [AVMM_BURST_W-1:0] burstcount,
    input  logic                    read,
    input  logic                    write,
    input  logic [AVMM_DATA_W-1:0]  writedata,
    input  logic [AVMM_BE_W-1:0]    byteenable,
    output logic                    waitrequest,
    output logic [AVMM_DATA_W-1:0]  readdata,
    output logic                    readdatavalid,
    output logic                    writeresponsevalid
);

    // Registered Avalon requests
    logic [AVMM_ADDR_W-1:0]  q_address;
    logic [AVMM_BURST_W-1:0] q_burstcount;
    logic                    q_read;
    logic                    q_write;
    logic [AVMM_DATA_W-1:0]  q_writedata;
    logic [AVMM_BE_W-1:0]    q_byteenable;
    logic                    q_waitrequest;

    // AXI channels
    logic                    awvalid;
    logic                    awready;
    t_axi_addr               awaddr;
    logic [AXI_LEN_W-1:0]    awlen;
    logic                    wvalid;
    logic                    wready;
    logic [AVMM_DATA_W-1:0]  wdata;
    logic [AVMM_BE_W-1:0]    wstrb;
    logic                    wlast;
    logic                    bvalid;
    logic                    arvalid;
    logic                    arready;
    t_axi_addr               araddr;
    logic [AXI_LEN_W-1:0]    arlen;
    logic                    rvalid;
    logic [AVMM_DATA_W-1:0]  rdata;

    avmm_reg_stage req_reg
    (
        .clk, .rst_n,
        .address, .burstcount, .read, .write, .writedata, .byteenable, .waitrequest,
        .q_address, .q_burstcount, .q_read, .q_write, .q_writedata, .q_byteenable,
        .q_waitrequest
    );

    avmm_to_axi_mapper mapper
    (
        .clk, .rst_n,
        .q_address, .q_burstcount, .q_read, .q_write, .q_writedata, .q_byteenable,
        .q_waitrequest,
        .awvalid, .awready, .awaddr, .awlen,
        .wvalid, .wready, .wdata, .wstrb, .wlast,
        .bvalid,
        .arvalid, .arready, .araddr, .arlen,
        .rvalid, .rdata,
        .readdata, .readdatavalid, .writeresponsevalid
    );

    // Burst ends are counted on the Avalon side, so rlast stays open
    axi_local_mem local_mem
    (
        .clk, .rst_n,
        .awvalid, .awready, .awaddr, .awlen,
        .wvalid, .wready, .wdata, .wstrb, .wlast,
        .bvalid,
        .arvalid, .arready, .araddr, .arlen,
        .rvalid, .rdata,
        .rlast ()
    );

endmodule

/* tb_local_mem_avmm_bridge.sv */
// --------------------
// Testbench for the Avalon to AXI local memory bridge
// Bookkeeping runs on the falling edge, checks on the rising edge
// Random mix stays inside a window that is filled first
// --------------------

`timescale 1ns/1ps

module tb_local_mem_avmm_bridge
    import avmm_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 4000;
    localparam int FILL_BASE      = 64;
    localparam int FILL_LINES     = 32;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic [AVMM_ADDR_W-1:0]  address;
    logic [AVMM_BURST_W-1:0] burstcount;
    logic                    read;
    logic                    write;
    logic [AVMM_DATA_W-1:0]  writedata;
    logic [AVMM_BE_W-1:0]    byteenable;
    logic                    waitrequest;
    logic [AVMM_DATA_W-1:0]  readdata;
    logic                    readdatavalid;
    logic                    writeresponsevalid;

    // Reference model state
    logic [AVMM_DATA_W-1:0]  shadow [1 << AVMM_ADDR_W];
    logic [AVMM_DATA_W-1:0]  exp_q [$];
    logic [AVMM_ADDR_W-1:0]  mon_line;
    logic [AVMM_BURST_W-1:0] mon_left = '0;
    int                      bursts_started = 0;
    int                      bursts_done = 0;
    int                      resp_seen = 0;
    int                      rd_beats_req = 0;
    int                      rd_beats_seen = 0;
    int                      cycle_cnt = 0;
    int                      errors = 0;
    integer                  seed;
    string                   test_name = "reset";
    bit                      saw_wait = 1'b0;

    // Latched for the checks on the next rising edge
    bit                      chk_reset = 1'b0;
    logic [2:0]              reset_word;
    bit                      chk_rd = 1'b0;
    bit                      chk_rd_extra;
    logic [AVMM_DATA_W-1:0]  chk_rd_exp;
    logic [AVMM_DATA_W-1:0]  chk_rd_got;
    string                   chk_rd_name;
    bit                      chk_resp = 1'b0;
    bit                      chk_resp_ok;
    bit                      end_chk = 1'b0;
    bit                      end_wait_chk = 1'b0;
    string                   end_name;
    int                      end_beats_exp;
    int                      end_beats_got;
    int                      end_resp_exp;
    int                      end_resp_got;

    local_mem_avmm_bridge local_mem_avmm_bridge_i
    (
        .clk, .rst_n,
        .address, .burstcount, .read, .write, .writedata, .byteenable, .waitrequest,
        .readdata, .readdatavalid, .writeresponsevalid
    );

    always #5 clk = ~clk;

    // Cycle count doubles as the run limit
    always @(posedge clk)
    begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // Acceptance seen here holds at the next rising edge
    always @(negedge clk)
    begin
        chk_reset  = (cycle_cnt >= 1) && (cycle_cnt <= 3);
        reset_word = {readdatavalid, writeresponsevalid, waitrequest};
        chk_rd     = 1'b0;
        chk_resp   = 1'b0;
        if (rst_n && waitrequest)
            saw_wait = 1'b1;

        if (rst_n && write && !waitrequest)
        begin
            // Address and length come from the first beat only
            if (mon_left == '0)
            begin
                mon_line = address;
                mon_left = burstcount;
                bursts_started++;
            end
            for (int i = 0; i < AVMM_BE_W; i++)
            begin
                if (byteenable[i])
                    shadow[mon_line][8*i +: 8] = writedata[8*i +: 8];
            end
            mon_line++;
            mon_left--;
            if (mon_left == '0)
                bursts_done++;
        end

        // Expected data snapshot at read acceptance
        if (rst_n && read && !waitrequest)
        begin
            for (int i = 0; i < burstcount; i++)
            begin
                exp_q.push_back(shadow[AVMM_ADDR_W'(address + i)]);
                rd_beats_req++;
            end
        end

        if (readdatavalid)
        begin
            chk_rd       = 1'b1;
            chk_rd_name  = test_name;
            chk_rd_got   = readdata;
            chk_rd_extra = (exp_q.size() == 0);
            chk_rd_exp   = chk_rd_extra ? '0 : exp_q.pop_front();
            rd_beats_seen++;
        end

        // A response may only follow a finished write burst
        if (writeresponsevalid)
        begin
            chk_resp    = 1'b1;
            chk_resp_ok = (resp_seen < bursts_done);
            resp_seen++;
        end
    end

    a_reset_idle: assert property (@(posedge clk) chk_reset |-> reset_word == 3'b000)
        else begin
            errors++;
            $display("Mismatch reset: expected %b, actual %b", 3'b000, reset_word);
        end

    a_read_expected: assert property (@(posedge clk) chk_rd |-> !chk_rd_extra)
        else begin
            errors++;
            $display("Error in %s: readdatavalid with no read outstanding", chk_rd_name);
        end

    a_read_data: assert property (
        @(posedge clk) chk_rd && !chk_rd_extra |-> chk_rd_got == chk_rd_exp
    )
        else begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", chk_rd_name, chk_rd_exp, chk_rd_got);
        end

    a_resp_legal: assert property (@(posedge clk) chk_resp |-> chk_resp_ok)
        else begin
            errors++;
            $display("Error in %s: write response without a finished write burst", test_name);
        end

    a_beat_total: assert property (@(posedge clk) end_chk |-> end_beats_got == end_beats_exp)
        else begin
            errors++;
            $display("Mismatch %s: expected %0d read beats, actual %0d",
                     end_name, end_beats_exp, end_beats_got);
        end

    a_resp_total: assert property (@(posedge clk) end_chk |-> end_resp_got == end_resp_exp)
        else begin
            errors++;
            $display("Mismatch %s: expected %0d write responses, actual %0d",
                     end_name, end_resp_exp, end_resp_got);
        end

    a_backpressure: assert property (@(posedge clk) end_wait_chk |-> saw_wait)
        else begin
            errors++;
            $display("Error in %s: waitrequest never rose under back-to-back reads", end_name);
        end

    // Depends on every address bit
    function automatic logic [AVMM_DATA_W-1:0] fill_word(input int line);
        return {16'hc0de ^ 16'(line), 16'(line * 7 + 3), ~16'(line), 16'h5a5a ^ 16'(line)};
    endfunction

    // Holds the current request until a cycle without waitrequest
    task automatic wait_accept();
        bit acc;
        do
        begin
            @(negedge clk);
            acc = !waitrequest;
            @(posedge clk);
            #1;
        end
        while (!acc);
    endtask

    task automatic write_burst(input int line, input int len, input logic [7:0] be,
                               input bit use_fill);
        for (int i = 0; i < len; i++)
        begin
            write      = 1'b1;
            read       = 1'b0;
            address    = AVMM_ADDR_W'(line);
            burstcount = AVMM_BURST_W'(len);
            writedata  = use_fill ? fill_word(line + i) : {$random(seed), $random(seed)};
            byteenable = be;
            wait_accept();
        end
        write = 1'b0;
    endtask

    task automatic read_burst(input int line, input int len);
        read       = 1'b1;
        write      = 1'b0;
        address    = AVMM_ADDR_W'(line);
        burstcount = AVMM_BURST_W'(len);
        wait_accept();
        read = 1'b0;
    endtask

    task automatic wait_writes();
        while (resp_seen != bursts_started)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_reads();
        while (exp_q.size() != 0)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    // One-cycle pulse that arms the total checks
    task automatic check_totals(input bit check_wait);
        end_name      = test_name;
        end_beats_exp = rd_beats_req;
        end_beats_got = rd_beats_seen;
        end_resp_exp  = bursts_done;
        end_resp_got  = resp_seen;
        end_chk       = 1'b1;
        end_wait_chk  = check_wait;
        @(posedge clk);
        #1;
        end_chk      = 1'b0;
        end_wait_chk = 1'b0;
    endtask

    initial
    begin
        int len;
        int line;
        seed       = 32'hc204d6e3;
        rst_n      = 1'b0;
        address    = '0;
        burstcount = AVMM_BURST_W'(1);
        read       = 1'b0;
        write      = 1'b0;
        writedata  = '0;
        byteenable = '0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (2) @(posedge clk);
        #1;

        test_name = "single";
        write_burst(5, 1, 8'hff, 1'b0);
        wait_writes();
        read_burst(5, 1);
        wait_reads();
        check_totals(1'b0);

        test_name = "burst";
        write_burst(16, 8, 8'hff, 1'b0);
        wait_writes();
        read_burst(16, 8);
        wait_reads();
        check_totals(1'b0);

        // Partial write over a known word
        test_name = "byteenable";
        write_burst(40, 1, 8'hff, 1'b0);
        wait_writes();
        write_burst(40, 1, 8'ha5, 1'b0);
        wait_writes();
        read_burst(40, 1);
        wait_reads();
        check_totals(1'b0);

        test_name = "fill";
        for (int b = 0; b < FILL_LINES / 8; b++)
            write_burst(FILL_BASE + 8 * b, 8, 8'hff, 1'b1);
        wait_writes();
        check_totals(1'b0);

        // Long reads keep arready low so the skid entry fills
        test_name = "backpressure";
        saw_wait  = 1'b0;
        read_burst(FILL_BASE, 8);
        read_burst(FILL_BASE + 8, 8);
        read_burst(FILL_BASE + 16, 3);
        read_burst(FILL_BASE + 24, 5);
        read_burst(16, 8);
        wait_reads();
        check_totals(1'b1);

        // Reads wait for writes, writes wait for reads to drain
        test_name = "random";
        for (int n = 0; n < 40; n++)
        begin
            len  = 1 + ($unsigned($random(seed)) % AVMM_MAX_BURST);
            line = FILL_BASE + ($unsigned($random(seed)) % (FILL_LINES - len + 1));
            if ($random(seed) & 1)
            begin
                wait_reads();
                write_burst(line, len, 8'($random(seed)), 1'b0);
            end
            else
            begin
                wait_writes();
                read_burst(line, len);
            end
        end
        wait_writes();
        wait_reads();
        check_totals(1'b0);

        repeat (4) @(posedge clk);
        $display("Read beats %0d, write responses %0d, errors %0d",
                 rd_beats_seen, resp_seen, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
